//--- max7219_pkg.sv
/*
 * MAX7219 wire-level definitions
 *   - 16-bit register word and the frame word with its last flag
 *   - register addresses
 *   - chain length and serial timing constants
 */
`default_nettype none

package max7219_pkg;

   // ====================
   // Chain and timing
   // ====================
   localparam int C_MATRIX_NB     = 8;
   localparam int C_HALF_PERIOD   = 4;
   localparam int C_LOAD_DURATION = 4;

   // ====================
   // Register addresses
   // ====================
   localparam logic [7:0] C_REG_DIGIT0     = 8'h01;
   localparam logic [7:0] C_REG_DECODE     = 8'h09;
   localparam logic [7:0] C_REG_INTENSITY  = 8'h0A;
   localparam logic [7:0] C_REG_SCAN_LIMIT = 8'h0B;
   localparam logic [7:0] C_REG_SHUTDOWN   = 8'h0C;
   localparam logic [7:0] C_REG_TEST       = 8'h0F;

   // Word as shifted out, address byte first
   typedef struct packed {
      logic [7:0] addr;
      logic [7:0] data;
   } max7219_word_t;

   // Load pulses after a word with last set
   typedef struct packed {
      max7219_word_t word;
      logic          last;
   } frame_word_t;

endpackage

`default_nettype wire

//--- ctrl_pkg.sv
/*
 * Controller-side definitions
 *   - RAM address type
 *   - configuration, host RAM request and player command structs
 */
`default_nettype none

package ctrl_pkg;

   localparam int C_RAM_ADDR_W = 8;

   typedef logic [C_RAM_ADDR_W-1:0] ram_addr_t;

   // Register contents sent to every matrix
   typedef struct packed {
      logic       display_test;
      logic [7:0] decode_mode;
      logic [7:0] intensity;
      logic [7:0] scan_limit;
      logic [7:0] shutdown;
   } cfg_t;

   // Host access, one port for read and write
   typedef struct packed {
      logic                       me;
      logic                       we;
      ram_addr_t                  addr;
      max7219_pkg::max7219_word_t wdata;
   } ram_req_t;

   typedef struct packed {
      ram_addr_t start_ptr;
      ram_addr_t last_ptr;
      logic      loop;
   } play_cmd_t;

endpackage

`default_nettype wire

//--- max7219_serializer.sv
/*
 * MAX7219 serializer
 *   - shifts one 16-bit word per handshake, MSB first
 *   - optional load pulse after the last word of a frame
 */
`timescale 1ns/1ns
`default_nettype none

module max7219_serializer (
   input  wire                      i_clk,
   input  wire                      i_rst,
   input  wire max7219_pkg::frame_word_t i_word,
   input  wire                      i_req,
   output logic                     o_ack,
   output logic                     o_max7219_clk,
   output logic                     o_max7219_data,
   output logic                     o_max7219_load
);
   import max7219_pkg::*;

   typedef logic [$clog2(C_HALF_PERIOD + C_LOAD_DURATION)-1:0] cnt_t;
   typedef enum logic [1:0] {S_IDLE, S_SHIFT, S_LOAD, S_ACK} state_t;

   state_t      state_q;
   cnt_t        cnt_q;
   logic [3:0]  bit_q;
   logic        sclk_q;
   logic        load_q;
   logic        ack_q;
   logic [15:0] shift_q;
   logic        last_q;
   logic        half_end;
   logic        bit_end;

   assign half_end = (cnt_q == cnt_t'(C_HALF_PERIOD - 1));
   // A bit ends on the second half, serial clock high
   assign bit_end  = half_end & sclk_q;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state_q <= S_IDLE;
         cnt_q   <= '0;
         bit_q   <= '0;
         sclk_q  <= 1'b0;
         load_q  <= 1'b0;
         ack_q   <= 1'b0;
      end else begin
         case (state_q)
            S_IDLE: begin
               if (i_req) begin
                  cnt_q   <= '0;
                  bit_q   <= '0;
                  state_q <= S_SHIFT;
               end
            end
            S_SHIFT: begin
               if (half_end) begin
                  cnt_q  <= '0;
                  sclk_q <= ~sclk_q;
                  if (bit_end) begin
                     if (bit_q == 4'd15) begin
                        load_q  <= last_q;
                        ack_q   <= ~last_q;
                        state_q <= last_q ? S_LOAD : S_ACK;
                     end else begin
                        bit_q <= bit_q + 4'd1;
                     end
                  end
               end else begin
                  cnt_q <= cnt_q + cnt_t'(1);
               end
            end
            S_LOAD: begin
               if (cnt_q == cnt_t'(C_LOAD_DURATION - 1)) begin
                  cnt_q   <= '0;
                  load_q  <= 1'b0;
                  ack_q   <= 1'b1;
                  state_q <= S_ACK;
               end else begin
                  cnt_q <= cnt_q + cnt_t'(1);
               end
            end
            default: begin
               // Hold ack until the source lets go of req
               if (!i_req) begin
                  ack_q   <= 1'b0;
                  state_q <= S_IDLE;
               end
            end
         endcase
      end
   end

   // Shift register, next bit appears as the serial clock falls
   always_ff @(posedge i_clk) begin
      if (state_q == S_IDLE && i_req) begin
         shift_q <= i_word.word;
         last_q  <= i_word.last;
      end else if (state_q == S_SHIFT && bit_end) begin
         shift_q <= {shift_q[14:0], 1'b0};
      end
   end

   assign o_ack          = ack_q;
   assign o_max7219_clk  = sclk_q;
   assign o_max7219_data = (state_q == S_SHIFT) & shift_q[15];
   assign o_max7219_load = load_q;

endmodule

`default_nettype wire

//--- static_ram.sv
/*
 * Static display RAM
 *   - 256 words of 16 bits
 *   - host read/write port and a player read port, both reads registered
 */
`timescale 1ns/1ns
`default_nettype none

module static_ram (
   input  wire                          i_clk,
   input  wire ctrl_pkg::ram_req_t      i_ram,
   output max7219_pkg::max7219_word_t   o_rdata,
   input  wire ctrl_pkg::ram_addr_t     i_rd_addr,
   output max7219_pkg::max7219_word_t   o_rd_data
);
   import max7219_pkg::*;
   import ctrl_pkg::*;

   max7219_word_t mem [2**C_RAM_ADDR_W];

   // Host port
   always_ff @(posedge i_clk) begin
      if (i_ram.me) begin
         if (i_ram.we) begin
            mem[i_ram.addr] <= i_ram.wdata;
         end else begin
            o_rdata <= mem[i_ram.addr];
         end
      end
   end

   // Player port, reads every cycle
   always_ff @(posedge i_clk) begin
      o_rd_data <= mem[i_rd_addr];
   end

endmodule

`default_nettype wire

//--- config_sequencer.sv
/*
 * Configuration sequencer
 *   - captures the host configuration on request
 *   - sends five register frames, one word per matrix
 */
`timescale 1ns/1ns
`default_nettype none

module config_sequencer (
   input  wire                      i_clk,
   input  wire                      i_rst,
   input  wire ctrl_pkg::cfg_t      i_cfg,
   input  wire                      i_cfg_req,
   output logic                     o_cfg_ack,
   output max7219_pkg::frame_word_t o_word,
   output logic                     o_req,
   input  wire                      i_ack
);
   import max7219_pkg::*;
   import ctrl_pkg::*;

   typedef logic [$clog2(C_MATRIX_NB)-1:0] word_cnt_t;
   typedef enum logic [1:0] {S_IDLE, S_REQ, S_WAIT, S_DONE} state_t;

   state_t        state_q;
   logic [2:0]    reg_idx_q;
   word_cnt_t     word_cnt_q;
   logic          req_q;
   logic          cfg_ack_q;
   cfg_t          cfg_q;
   max7219_word_t reg_word;
   logic          frame_end;

   // Register order: test, decode, intensity, scan limit, shutdown
   always_comb begin
      case (reg_idx_q)
         3'd0:    reg_word = '{addr: C_REG_TEST, data: {7'd0, cfg_q.display_test}};
         3'd1:    reg_word = '{addr: C_REG_DECODE, data: cfg_q.decode_mode};
         3'd2:    reg_word = '{addr: C_REG_INTENSITY, data: cfg_q.intensity};
         3'd3:    reg_word = '{addr: C_REG_SCAN_LIMIT, data: cfg_q.scan_limit};
         default: reg_word = '{addr: C_REG_SHUTDOWN, data: cfg_q.shutdown};
      endcase
   end

   assign frame_end = (word_cnt_q == word_cnt_t'(C_MATRIX_NB - 1));

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state_q    <= S_IDLE;
         reg_idx_q  <= '0;
         word_cnt_q <= '0;
         req_q      <= 1'b0;
         cfg_ack_q  <= 1'b0;
      end else begin
         case (state_q)
            S_IDLE: begin
               if (i_cfg_req) begin
                  reg_idx_q  <= '0;
                  word_cnt_q <= '0;
                  req_q      <= 1'b1;
                  state_q    <= S_REQ;
               end
            end
            S_REQ: begin
               if (i_ack) begin
                  req_q   <= 1'b0;
                  state_q <= S_WAIT;
               end
            end
            S_WAIT: begin
               if (!i_ack) begin
                  if (frame_end && reg_idx_q == 3'd4) begin
                     cfg_ack_q <= 1'b1;
                     state_q   <= S_DONE;
                  end else begin
                     if (frame_end) begin
                        reg_idx_q <= reg_idx_q + 3'd1;
                     end
                     word_cnt_q <= word_cnt_q + word_cnt_t'(1);
                     req_q      <= 1'b1;
                     state_q    <= S_REQ;
                  end
               end
            end
            default: begin
               if (!i_cfg_req) begin
                  cfg_ack_q <= 1'b0;
                  state_q   <= S_IDLE;
               end
            end
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (state_q == S_IDLE && i_cfg_req) begin
         cfg_q <= i_cfg;
      end
   end

   assign o_word    = {reg_word, frame_end};
   assign o_req     = req_q;
   assign o_cfg_ack = cfg_ack_q;

endmodule

`default_nettype wire

//--- static_player.sv
/*
 * Static player
 *   - walks RAM from the start pointer to the last pointer
 *   - cuts the stream in frames of one word per matrix, optional loop
 */
`timescale 1ns/1ns
`default_nettype none

module static_player (
   input  wire                        i_clk,
   input  wire                        i_rst,
   input  wire ctrl_pkg::play_cmd_t   i_play,
   input  wire                        i_play_en,
   output logic                       o_busy,
   output ctrl_pkg::ram_addr_t        o_rd_addr,
   input  wire max7219_pkg::max7219_word_t i_rd_data,
   output max7219_pkg::frame_word_t   o_word,
   output logic                       o_req,
   input  wire                        i_ack
);
   import max7219_pkg::*;
   import ctrl_pkg::*;

   typedef logic [$clog2(C_MATRIX_NB)-1:0] frm_cnt_t;
   typedef enum logic [2:0] {S_IDLE, S_FETCH, S_CAPT, S_REQ, S_WAIT} state_t;

   state_t        state_q;
   logic          en_q;
   logic          busy_q;
   logic          req_q;
   ram_addr_t     addr_q;
   frm_cnt_t      frm_cnt_q;
   play_cmd_t     cmd_q;
   max7219_word_t word_q;
   logic          last_q;
   logic          start;
   logic          at_last;
   logic          stop;

   assign start   = (state_q == S_IDLE) & i_play_en & ~en_q;
   assign at_last = (addr_q == cmd_q.last_ptr);
   // Looping stops only on a frame boundary
   assign stop    = (at_last & ~cmd_q.loop) | (last_q & cmd_q.loop & ~i_play_en);

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state_q   <= S_IDLE;
         en_q      <= 1'b0;
         busy_q    <= 1'b0;
         req_q     <= 1'b0;
         addr_q    <= '0;
         frm_cnt_q <= '0;
      end else begin
         en_q <= i_play_en;
         case (state_q)
            S_IDLE: begin
               if (start) begin
                  addr_q    <= i_play.start_ptr;
                  frm_cnt_q <= '0;
                  busy_q    <= 1'b1;
                  state_q   <= S_FETCH;
               end
            end
            // RAM read latency
            S_FETCH: state_q <= S_CAPT;
            S_CAPT: begin
               req_q   <= 1'b1;
               state_q <= S_REQ;
            end
            S_REQ: begin
               if (i_ack) begin
                  req_q   <= 1'b0;
                  state_q <= S_WAIT;
               end
            end
            default: begin
               if (!i_ack) begin
                  if (stop) begin
                     busy_q  <= 1'b0;
                     state_q <= S_IDLE;
                  end else begin
                     addr_q    <= at_last ? cmd_q.start_ptr : addr_q + ram_addr_t'(1);
                     frm_cnt_q <= last_q ? '0 : frm_cnt_q + frm_cnt_t'(1);
                     state_q   <= S_FETCH;
                  end
               end
            end
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (start) begin
         cmd_q <= i_play;
      end
      if (state_q == S_CAPT) begin
         word_q <= i_rd_data;
         last_q <= at_last | (frm_cnt_q == frm_cnt_t'(C_MATRIX_NB - 1));
      end
   end

   assign o_busy    = busy_q;
   assign o_rd_addr = addr_q;
   assign o_word    = {word_q, last_q};
   assign o_req     = req_q;

endmodule

`default_nettype wire

//--- frame_arbiter.sv
/*
 * Frame arbiter
 *   - grants the serializer to the sequencer or the player
 *   - grant held for a whole frame, sequencer wins a tie
 */
`timescale 1ns/1ns
`default_nettype none

module frame_arbiter (
   input  wire                           i_clk,
   input  wire                           i_rst,
   input  wire max7219_pkg::frame_word_t i_cfg_word,
   input  wire                           i_cfg_req,
   output logic                          o_cfg_ack,
   input  wire max7219_pkg::frame_word_t i_play_word,
   input  wire                           i_play_req,
   output logic                          o_play_ack,
   output max7219_pkg::frame_word_t      o_word,
   output logic                          o_req,
   input  wire                           i_ack
);
   logic grant_q;
   logic sel_play_q;
   logic done_q;

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         grant_q    <= 1'b0;
         sel_play_q <= 1'b0;
         done_q     <= 1'b0;
      end else if (!grant_q) begin
         if (i_cfg_req) begin
            grant_q    <= 1'b1;
            sel_play_q <= 1'b0;
         end else if (i_play_req) begin
            grant_q    <= 1'b1;
            sel_play_q <= 1'b1;
         end
      end else if (done_q) begin
         // Release once the last handshake is fully closed
         if (!i_ack) begin
            grant_q <= 1'b0;
            done_q  <= 1'b0;
         end
      end else if (o_req && i_ack && o_word.last) begin
         done_q <= 1'b1;
      end
   end

   assign o_word     = sel_play_q ? i_play_word : i_cfg_word;
   assign o_req      = grant_q & (sel_play_q ? i_play_req : i_cfg_req);
   assign o_cfg_ack  = grant_q & ~sel_play_q & i_ack;
   assign o_play_ack = grant_q & sel_play_q & i_ack;

endmodule

`default_nettype wire

//--- max7219_display_controller.sv
/*
 * MAX7219 display controller top
 *   - configuration sequencer, static RAM and player
 *   - frame arbiter and serializer driving the chain
 */
`timescale 1ns/1ns
`default_nettype none

module max7219_display_controller (
   input  wire                        i_clk,
   input  wire                        i_rst,
   input  wire ctrl_pkg::cfg_t        i_cfg,
   input  wire                        i_cfg_req,
   output logic                       o_cfg_ack,
   input  wire ctrl_pkg::ram_req_t    i_ram,
   output max7219_pkg::max7219_word_t o_rdata,
   input  wire ctrl_pkg::play_cmd_t   i_play,
   input  wire                        i_play_en,
   output logic                       o_busy,
   output logic                       o_max7219_clk,
   output logic                       o_max7219_data,
   output logic                       o_max7219_load
);
   import max7219_pkg::*;
   import ctrl_pkg::*;

   // ====================
   // Internal links
   // ====================
   frame_word_t   cfg_word;
   logic          cfg_req;
   logic          cfg_ack;
   frame_word_t   play_word;
   logic          play_req;
   logic          play_ack;
   frame_word_t   ser_word;
   logic          ser_req;
   logic          ser_ack;
   ram_addr_t     rd_addr;
   max7219_word_t rd_data;

   config_sequencer config_sequencer_inst (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_cfg     (i_cfg),
      .i_cfg_req (i_cfg_req),
      .o_cfg_ack (o_cfg_ack),
      .o_word    (cfg_word),
      .o_req     (cfg_req),
      .i_ack     (cfg_ack)
   );

   static_ram static_ram_inst (
      .i_clk     (i_clk),
      .i_ram     (i_ram),
      .o_rdata   (o_rdata),
      .i_rd_addr (rd_addr),
      .o_rd_data (rd_data)
   );

   static_player static_player_inst (
      .i_clk     (i_clk),
      .i_rst     (i_rst),
      .i_play    (i_play),
      .i_play_en (i_play_en),
      .o_busy    (o_busy),
      .o_rd_addr (rd_addr),
      .i_rd_data (rd_data),
      .o_word    (play_word),
      .o_req     (play_req),
      .i_ack     (play_ack)
   );

   // Serializer sharing
   frame_arbiter frame_arbiter_inst (
      .i_clk       (i_clk),
      .i_rst       (i_rst),
      .i_cfg_word  (cfg_word),
      .i_cfg_req   (cfg_req),
      .o_cfg_ack   (cfg_ack),
      .i_play_word (play_word),
      .i_play_req  (play_req),
      .o_play_ack  (play_ack),
      .o_word      (ser_word),
      .o_req       (ser_req),
      .i_ack       (ser_ack)
   );

   max7219_serializer max7219_serializer_inst (
      .i_clk          (i_clk),
      .i_rst          (i_rst),
      .i_word         (ser_word),
      .i_req          (ser_req),
      .o_ack          (ser_ack),
      .o_max7219_clk  (o_max7219_clk),
      .o_max7219_data (o_max7219_data),
      .o_max7219_load (o_max7219_load)
   );

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
/*
 * Testbench clock and reset
 *   - 20 ns clock
 *   - reset held high for 16 cycles, released on a falling edge
 */
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
   output logic o_clk,
   output logic o_rst
);
   localparam int C_PERIOD_NS  = 20;
   localparam int C_RST_CYCLES = 16;

   initial begin
      o_clk = 1'b0;
      forever #(C_PERIOD_NS / 2) o_clk = ~o_clk;
   end

   initial begin
      o_rst = 1'b1;
      repeat (C_RST_CYCLES) @(negedge o_clk);
      o_rst = 1'b0;
   end

endmodule

`default_nettype wire

//--- tb_top.sv
/*
 * Testbench for the MAX7219 display controller
 *   - stimulus table applied in a loop
 *   - serial decoder collecting words and load-terminated frames
 *   - compare tasks for words, levels and counts
 */
`timescale 1ns/1ns
`default_nettype none

module tb_top;
   import max7219_pkg::*;
   import ctrl_pkg::*;

   localparam int C_TIMEOUT = 50000;
   localparam int C_ROW_NB  = 7;
   localparam int C_CFG_NB  = 5;

   typedef enum logic [2:0] {OP_CFG, OP_WRITE, OP_READ, OP_PLAY, OP_LOOP, OP_MIX} op_t;
   typedef enum logic [1:0] {SIG_RST, SIG_CFG_ACK, SIG_BUSY, SIG_SCLK} probe_t;

   // Expected config words, one per register in send order
   typedef max7219_word_t [0:C_CFG_NB-1] cfg_words_t;

   typedef struct packed {
      op_t           op;
      cfg_t          cfg;
      cfg_words_t    exp_cfg;
      ram_addr_t     addr;
      max7219_word_t wdata;
      play_cmd_t     play;
   } row_t;

   logic          clk;
   logic          rst;
   cfg_t          cfg;
   logic          cfg_req;
   logic          cfg_ack;
   ram_req_t      ram;
   max7219_word_t rdata;
   play_cmd_t     play;
   logic          play_en;
   logic          busy;
   logic          sclk;
   logic          sdata;
   logic          sload;

   row_t          rows [C_ROW_NB];
   max7219_word_t ref_mem [256];
   int            seed;
   int            r;

   // Decoded serial stream and expected player stream
   max7219_word_t words [$];
   int            frame_lens [$];
   max7219_word_t exp_words [$];
   int            exp_lens [$];
   logic [15:0]   shift_in;
   int            bit_cnt;
   int            pending;
   logic          sclk_prev;
   logic          load_prev;

   tb_clock_gen tb_clock_gen_inst (
      .o_clk (clk),
      .o_rst (rst)
   );

   max7219_display_controller max7219_display_controller_inst (
      .i_clk          (clk),
      .i_rst          (rst),
      .i_cfg          (cfg),
      .i_cfg_req      (cfg_req),
      .o_cfg_ack      (cfg_ack),
      .i_ram          (ram),
      .o_rdata        (rdata),
      .i_play         (play),
      .i_play_en      (play_en),
      .o_busy         (busy),
      .o_max7219_clk  (sclk),
      .o_max7219_data (sdata),
      .o_max7219_load (sload)
   );

   // ====================
   // Checks
   // ====================
   task automatic report_failure(input string why);
      $display("%s", why);
      $display("Checks failed");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input max7219_word_t got,
                             input max7219_word_t exp);
      if (got !== exp) begin
         report_failure($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         report_failure($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      if (got != exp) begin
         report_failure($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
      end
   endtask

   // ====================
   // Serial decoder
   // ====================
   // Data is stable while the serial clock rises
   always @(negedge clk) begin
      if (rst) begin
         bit_cnt = 0;
         pending = 0;
      end else begin
         if (sclk && !sclk_prev) begin
            shift_in = {shift_in[14:0], sdata};
            bit_cnt  = bit_cnt + 1;
            if (bit_cnt == 16) begin
               words.push_back(max7219_word_t'(shift_in));
               pending = pending + 1;
               bit_cnt = 0;
            end
         end
         if (sload && !load_prev) begin
            if (bit_cnt != 0) begin
               report_failure("Load pulsed in the middle of a word");
            end
            frame_lens.push_back(pending);
            pending = 0;
         end
      end
      sclk_prev = sclk;
      load_prev = sload;
   end

   // ====================
   // Waits
   // ====================
   function automatic logic level_of(input probe_t p);
      case (p)
         SIG_RST:     level_of = rst;
         SIG_CFG_ACK: level_of = cfg_ack;
         SIG_BUSY:    level_of = busy;
         default:     level_of = sclk;
      endcase
   endfunction

   task automatic wait_level(input probe_t p, input logic level, input string what);
      int n;
      n = 0;
      while (level_of(p) !== level && n < C_TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (level_of(p) !== level) begin
         report_failure($sformatf("Timeout while waiting for %s", what));
      end
   endtask

   task automatic wait_frame(output int len);
      int n;
      n = 0;
      while (frame_lens.size() == 0 && n < C_TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (frame_lens.size() == 0) begin
         report_failure("Timeout while waiting for a load pulse");
      end
      len = frame_lens.pop_front();
      if (len == 0) begin
         report_failure("Load pulse with no word before it");
      end
   endtask

   // ====================
   // Expected values
   // ====================
   function automatic logic is_cfg_addr(input logic [7:0] a);
      is_cfg_addr = a inside {C_REG_TEST, C_REG_DECODE, C_REG_INTENSITY,
                              C_REG_SCAN_LIMIT, C_REG_SHUTDOWN};
   endfunction

   // One pass from start to last, cut every 8 words and at the last pointer
   task automatic build_play(input play_cmd_t cmd);
      ram_addr_t a;
      int        cnt;
      logic      done;
      exp_words.delete();
      exp_lens.delete();
      a    = cmd.start_ptr;
      cnt  = 0;
      done = 1'b0;
      while (!done) begin
         exp_words.push_back(ref_mem[a]);
         cnt++;
         done = (a == cmd.last_ptr);
         if (cnt == C_MATRIX_NB || done) begin
            exp_lens.push_back(cnt);
            cnt = 0;
         end
         a = ram_addr_t'(a + 1);
      end
   endtask

   task automatic check_ram_frame(input int len, input int idx);
      int f;
      int base;
      int i;
      f    = idx % exp_lens.size();
      base = 0;
      for (i = 0; i < f; i++) begin
         base += exp_lens[i];
      end
      check_count("player frame length", len, exp_lens[f]);
      for (i = 0; i < len; i++) begin
         check_word("player word", words.pop_front(), exp_words[base + i]);
      end
   endtask

   task automatic check_cfg_frame(input int len, input max7219_word_t exp);
      int i;
      check_count("config frame length", len, C_MATRIX_NB);
      for (i = 0; i < len; i++) begin
         check_word("config word", words.pop_front(), exp);
      end
   endtask

   task automatic check_idle_end();
      check_bit("o_busy", busy, 1'b0);
      check_count("words without a load", pending, 0);
      check_count("bits of an unfinished word", bit_cnt, 0);
      check_count("unread words", words.size(), 0);
   endtask

   // ====================
   // Operations
   // ====================
   task automatic fill_ram();
      int a;
      int rnd;
      for (a = 0; a < 256; a++) begin
         rnd = $random(seed);
         @(negedge clk);
         ram = '{me: 1'b1, we: 1'b1, addr: ram_addr_t'(a),
                 wdata: '{addr: C_REG_DIGIT0 + 8'(a % 8), data: rnd[7:0]}};
         ref_mem[a] = ram.wdata;
      end
      @(negedge clk);
      ram.me = 1'b0;
   endtask

   task automatic finish_cfg();
      wait_level(SIG_CFG_ACK, 1'b1, "o_cfg_ack to rise");
      repeat (3) @(negedge clk);
      check_bit("o_cfg_ack", cfg_ack, 1'b1);
      cfg_req = 1'b0;
      wait_level(SIG_CFG_ACK, 1'b0, "o_cfg_ack to fall");
   endtask

   task automatic run_cfg(input cfg_t c, input cfg_words_t exp);
      int f;
      int len;
      @(negedge clk);
      cfg     = c;
      cfg_req = 1'b1;
      for (f = 0; f < C_CFG_NB; f++) begin
         wait_frame(len);
         if (f < C_CFG_NB - 1) begin
            check_bit("o_cfg_ack", cfg_ack, 1'b0);
         end
         check_cfg_frame(len, exp[f]);
      end
      finish_cfg();
   endtask

   task automatic run_write(input ram_addr_t a, input max7219_word_t w);
      @(negedge clk);
      ram = '{me: 1'b1, we: 1'b1, addr: a, wdata: w};
      ref_mem[a] = w;
      @(negedge clk);
      ram.me = 1'b0;
   endtask

   task automatic run_read(input ram_addr_t a);
      @(negedge clk);
      ram = '{me: 1'b1, we: 1'b0, addr: a, wdata: '0};
      @(negedge clk);
      ram.me = 1'b0;
      check_word("o_rdata", rdata, ref_mem[a]);
   endtask

   task automatic start_play(input play_cmd_t cmd);
      build_play(cmd);
      @(negedge clk);
      play    = cmd;
      play_en = 1'b1;
   endtask

   task automatic run_play(input play_cmd_t cmd);
      int f;
      int len;
      start_play(cmd);
      for (f = 0; f < exp_lens.size(); f++) begin
         wait_frame(len);
         if (f == 0) begin
            check_bit("o_busy", busy, 1'b1);
         end
         check_ram_frame(len, f);
      end
      wait_level(SIG_BUSY, 1'b0, "o_busy to fall");
      @(negedge clk);
      play_en = 1'b0;
      check_idle_end();
   endtask

   // One frame past a full pass, so the wrap is seen
   task automatic run_loop(input play_cmd_t cmd);
      int f;
      int len;
      int n;
      start_play(cmd);
      for (f = 0; f <= exp_lens.size(); f++) begin
         wait_frame(len);
         check_ram_frame(len, f);
      end
      // Play enable drops inside the next frame
      n = 0;
      while (words.size() == 0 && n < C_TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (words.size() == 0) begin
         report_failure("Timeout while waiting for a word of the next frame");
      end
      @(negedge clk);
      play_en = 1'b0;
      wait_level(SIG_BUSY, 1'b0, "o_busy to fall after play stop");
      while (frame_lens.size() > 0) begin
         len = frame_lens.pop_front();
         check_ram_frame(len, f);
         f++;
      end
      check_idle_end();
   endtask

   task automatic run_mix(input play_cmd_t cmd, input cfg_t c, input cfg_words_t exp);
      int   k;
      int   len;
      int   ram_f;
      int   cfg_f;
      logic from_cfg;
      start_play(cmd);
      wait_level(SIG_SCLK, 1'b1, "the serial clock during play");
      @(negedge clk);
      cfg     = c;
      cfg_req = 1'b1;
      ram_f   = 0;
      cfg_f   = 0;
      for (k = 0; k < exp_lens.size() + C_CFG_NB; k++) begin
         wait_frame(len);
         from_cfg = is_cfg_addr(words[0].addr);
         if (k == 0 && from_cfg) begin
            report_failure("Config frame went out ahead of the player frame in progress");
         end
         if (from_cfg) begin
            if (cfg_f == C_CFG_NB) begin
               report_failure("More config frames than registers");
            end
            check_cfg_frame(len, exp[cfg_f]);
            cfg_f++;
         end else begin
            if (ram_f == exp_lens.size()) begin
               report_failure("More player frames than the pointers allow");
            end
            check_ram_frame(len, ram_f);
            ram_f++;
         end
      end
      finish_cfg();
      wait_level(SIG_BUSY, 1'b0, "o_busy to fall");
      @(negedge clk);
      play_en = 1'b0;
      check_idle_end();
   endtask

   function automatic row_t make_row(input op_t op, input cfg_t c, input cfg_words_t e,
                                     input ram_addr_t a, input max7219_word_t w,
                                     input play_cmd_t p);
      make_row = '{op: op, cfg: c, exp_cfg: e, addr: a, wdata: w, play: p};
   endfunction

   // ====================
   // Main sequence
   // ====================
   initial begin
      cfg     = '0;
      cfg_req = 1'b0;
      ram     = '0;
      play    = '0;
      play_en = 1'b0;
      seed    = 23;

      rows[0] = make_row(OP_CFG, cfg_t'({1'b1, 8'h00, 8'h07, 8'h07, 8'h01}),
                         {16'h0F01, 16'h0900, 16'h0A07, 16'h0B07, 16'h0C01},
                         8'h00, 16'h0000, '0);
      rows[1] = make_row(OP_WRITE, '0, '0, 8'h10, 16'h03A5, '0);
      rows[2] = make_row(OP_READ, '0, '0, 8'h10, 16'h0000, '0);
      rows[3] = make_row(OP_READ, '0, '0, 8'h9F, 16'h0000, '0);
      // 12 words, two frames
      rows[4] = make_row(OP_PLAY, '0, '0, 8'h00, 16'h0000,
                         play_cmd_t'({8'h20, 8'h2B, 1'b0}));
      rows[5] = make_row(OP_LOOP, '0, '0, 8'h00, 16'h0000,
                         play_cmd_t'({8'h40, 8'h49, 1'b1}));
      rows[6] = make_row(OP_MIX, cfg_t'({1'b0, 8'hFF, 8'h03, 8'h07, 8'h01}),
                         {16'h0F00, 16'h09FF, 16'h0A03, 16'h0B07, 16'h0C01},
                         8'h00, 16'h0000, play_cmd_t'({8'h60, 8'h77, 1'b0}));

      wait_level(SIG_RST, 1'b0, "reset release");
      @(negedge clk);
      check_bit("o_max7219_clk", sclk, 1'b0);
      check_bit("o_max7219_data", sdata, 1'b0);
      check_bit("o_max7219_load", sload, 1'b0);
      check_bit("o_cfg_ack", cfg_ack, 1'b0);
      check_bit("o_busy", busy, 1'b0);

      fill_ram();

      for (r = 0; r < C_ROW_NB; r++) begin
         case (rows[r].op)
            OP_CFG:   run_cfg(rows[r].cfg, rows[r].exp_cfg);
            OP_WRITE: run_write(rows[r].addr, rows[r].wdata);
            OP_READ:  run_read(rows[r].addr);
            OP_PLAY:  run_play(rows[r].play);
            OP_LOOP:  run_loop(rows[r].play);
            default:  run_mix(rows[r].play, rows[r].cfg, rows[r].exp_cfg);
         endcase
      end

      repeat (4) @(negedge clk);
      if (words.size() == 0 && frame_lens.size() == 0) begin
         $display("All checks passed");
         $finish;
      end else begin
         report_failure("Serial output appeared after the last operation");
      end
   end

endmodule

`default_nettype wire

//--- build.f
max7219_pkg.sv
ctrl_pkg.sv
max7219_serializer.sv
static_ram.sv
config_sequencer.sv
static_player.sv
frame_arbiter.sv
max7219_display_controller.sv
tb_clock_gen.sv
tb_top.sv

//--- run.sh
#!/bin/sh
# Compile and run the testbench with Verilator.
# The exit status of the simulation is the test result.
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_top -f build.f -o sim_tb_top

./obj_dir/sim_tb_top
